// ==== Makefile ====
# Verilator build and run for the SPI link testbench

VERILATOR  ?= verilator
TOP        ?= tb_spi_link
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb.f ====
+incdir+verilog
verilog/axil_pkg.sv
verilog/spi_pkg.sv
verilog/spi_master.sv
verilog/spi_slave.sv
verilog/spi_ctrl_regs.sv
verilog/spi_link_top.sv
tests/tb_spi_link.sv

// ==== tests/tb_spi_link.sv ====
//************************************************
// tb_spi_link
// random register and loopback transfer test of the
// AXI4-Lite SPI link against a register model
//************************************************
`timescale 1ns/1ps
`include "spi_params.svh"

module tb_spi_link
	import axil_pkg::*;
	import spi_pkg::*;
();

	localparam int CLK_PERIOD      = 4;
	localparam int NUM_XFERS       = 46;        // random, start while busy, stalled
	localparam int MAX_DIV         = 10;
	localparam int WATCHDOG_CYCLES = NUM_XFERS * (34 * (MAX_DIV + 1) + 200);

	logic       sys_clk;
	logic       sys_rst_n;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	logic       awvalid, awready, wvalid, wready, bvalid, bready;
	logic       arvalid, arready, rvalid, rready;
	axil_resp_t bresp, rresp;

	integer    seed      = 96;
	int        errors    = 0;
	int        checks    = 0;
	int        max_stall = 3;              // longest bready/rready hold-off
	spi_byte_t exp_mtx, exp_stx;           // register model
	spi_div_t  exp_div;

	spi_link_top spi_link_top_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic spi_div_t clamp_div(input spi_div_t d);
		return (d < `SPI_MIN_DIV) ? spi_div_t'(`SPI_MIN_DIV) : d;
	endfunction

	function automatic bit is_mapped(input axil_addr_t a);
		return a inside {`REG_CTRL, `REG_MTX, `REG_STX, `REG_DIV, `REG_STATUS, `REG_RESULT};
	endfunction

	task automatic expect_word(input string what, input axil_data_t got, input axil_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic hold_off();
		int n;
		n = $unsigned($random(seed)) % (max_stall + 1);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
				 output axil_resp_t resp);
		logic hs;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do begin
			@(negedge sys_clk);
			hs = awready && wready;
			@(posedge sys_clk);
			#1;
		end while (!hs);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		hold_off();                         // keep bready low for a while
		bready = 1'b1;
		do begin
			@(negedge sys_clk);
			hs   = bvalid;
			resp = bresp;
			@(posedge sys_clk);
			#1;
		end while (!hs);
		bready = 1'b0;
		checks++;
		if (bvalid) begin
			errors++;
			$display("write response for address %h stayed valid after it was taken", addr);
		end
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
				output axil_resp_t resp);
		logic hs;
		araddr  = addr;
		arvalid = 1'b1;
		do begin
			@(negedge sys_clk);
			hs = arready;
			@(posedge sys_clk);
			#1;
		end while (!hs);
		arvalid = 1'b0;
		hold_off();
		rready = 1'b1;
		do begin
			@(negedge sys_clk);
			hs   = rvalid;
			data = rdata;
			resp = rresp;
			@(posedge sys_clk);
			#1;
		end while (!hs);
		rready = 1'b0;
		checks++;
		if (rvalid) begin
			errors++;
			$display("read response for address %h stayed valid after it was taken", addr);
		end
	endtask

	task automatic model_write(input axil_addr_t addr, input axil_data_t data);
		case (addr)
			`REG_MTX: exp_mtx = data[7:0];
			`REG_STX: exp_stx = data[7:0];
			`REG_DIV: exp_div = clamp_div(data[15:0]);
			default: ;
		endcase
	endtask

	task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
		axil_resp_t resp;
		axi_write(addr, data, resp);
		expect_word("write response", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
		model_write(addr, data);
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
		axil_resp_t resp;
		axi_read(addr, data, resp);
		expect_word("read response", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
	endtask

	task automatic check_config();
		axil_data_t data;
		read_reg(`REG_MTX, data);
		expect_word("MTX", data, axil_data_t'(exp_mtx));
		read_reg(`REG_STX, data);
		expect_word("STX", data, axil_data_t'(exp_stx));
		read_reg(`REG_DIV, data);
		expect_word("DIV", data, axil_data_t'(exp_div));
	endtask

	task automatic wait_done(output axil_data_t status);
		do
			read_reg(`REG_STATUS, status);
		while (!status[1]);
	endtask

	task automatic check_transfer(input spi_div_t d);
		axil_data_t status, result;
		write_reg(`REG_MTX, $random(seed));
		write_reg(`REG_STX, $random(seed));
		write_reg(`REG_DIV, axil_data_t'(d));
		write_reg(`REG_CTRL, 32'h1);
		wait_done(status);
		expect_word("STATUS busy after done", axil_data_t'(status[0]), 0);
		read_reg(`REG_RESULT, result);
		// master gets the slave byte, slave gets the master byte
		expect_word("RESULT", result, {16'h0, exp_mtx, exp_stx});
	endtask

	task automatic randomize_config();
		axil_data_t d;
		write_reg(`REG_MTX, $random(seed));
		write_reg(`REG_STX, $random(seed));
		d = $random(seed);
		if ($random(seed) & 1)
			d = $unsigned($random(seed)) % 3;   // below the minimum
		write_reg(`REG_DIV, d);
		check_config();
	endtask

	initial begin : main
		axil_data_t data, status;
		axil_resp_t resp;
		axil_addr_t addr;
		spi_byte_t  first_m, first_s;
		int         i;

		sys_rst_n = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		exp_mtx   = '0;
		exp_stx   = '0;
		exp_div   = spi_div_t'(`SPI_MIN_DIV);
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		read_reg(`REG_STATUS, data);
		expect_word("STATUS after reset", data, 0);
		read_reg(`REG_RESULT, data);
		expect_word("RESULT after reset", data, 0);

		for (i = 0; i < 20; i++)
			randomize_config();

		for (i = 0; i < 40; i++)
			check_transfer(spi_div_t'(3 + $unsigned($random(seed)) % 8));

		// second start during a frame must be dropped
		write_reg(`REG_MTX, $random(seed));
		write_reg(`REG_STX, $random(seed));
		write_reg(`REG_DIV, MAX_DIV);
		first_m = exp_mtx;
		first_s = exp_stx;
		write_reg(`REG_CTRL, 32'h1);
		read_reg(`REG_STATUS, status);
		expect_word("STATUS busy after start", axil_data_t'(status[0]), 1);
		repeat (8) @(posedge sys_clk);      // slave has loaded its byte by now
		#1;
		write_reg(`REG_MTX, $random(seed));
		write_reg(`REG_STX, $random(seed));
		write_reg(`REG_CTRL, 32'h1);
		wait_done(status);
		read_reg(`REG_RESULT, data);
		expect_word("RESULT with start while busy", data, {16'h0, first_m, first_s});
		repeat (34 * (MAX_DIV + 1)) @(posedge sys_clk);
		#1;
		read_reg(`REG_STATUS, status);
		expect_word("STATUS long after done", status, 32'h2);
		read_reg(`REG_RESULT, data);
		expect_word("RESULT long after done", data, {16'h0, first_m, first_s});

		for (i = 0; i < 8; i++) begin
			do
				addr = axil_addr_t'($random(seed));
			while (is_mapped(addr));
			axi_write(addr, $random(seed), resp);
			expect_word("unmapped write response", axil_data_t'(resp),
				    axil_data_t'(RESP_SLVERR));
			axi_read(addr, data, resp);
			expect_word("unmapped read response", axil_data_t'(resp),
				    axil_data_t'(RESP_SLVERR));
			expect_word("unmapped read data", data, 0);
		end
		check_config();

		max_stall = 15;                     // long back-pressure stretches
		for (i = 0; i < 4; i++)
			randomize_config();
		for (i = 0; i < 5; i++)
			check_transfer(spi_div_t'(3 + $unsigned($random(seed)) % 8));

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog/axil_pkg.sv ====
//************************************************
// axil_pkg
// host bus types for the AXI4-Lite register port
//************************************************
`include "spi_params.svh"

package axil_pkg;

	// byte address on the register port
	typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

	// one full register word
	typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

	// write and read response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,        // access done
		RESP_SLVERR = 2'b10         // unmapped address
	} axil_resp_t;

endpackage

// ==== verilog/spi_ctrl_regs.sv ====
//************************************************
// spi_ctrl_regs
// AXI4-Lite register file, starts a transfer and
// joins the master and slave results
//************************************************
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_ctrl_regs
	import axil_pkg::*;
	import spi_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready,
	output logic       start,
	output spi_byte_t  m_tx,
	output spi_div_t   div,
	input  logic       m_busy,
	input  logic       m_done,
	input  spi_byte_t  m_rx,
	output spi_byte_t  s_tx,
	input  spi_byte_t  s_rx,
	input  logic       s_rx_valid
);

	logic       wr_fire, rd_fire;
	logic       wr_ok, rd_ok;
	axil_data_t rd_data;
	logic       busy, done;
	logic       m_seen, s_seen;         // each half of the result has arrived
	spi_byte_t  m_rx_q, s_rx_q;
	spi_div_t   wr_div;
	logic       start_req;

	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;

	assign wr_div    = spi_div_t'(wdata);
	assign start_req = wr_fire && awaddr == `REG_CTRL && wdata[0] && !busy && !m_busy;

	always_comb begin
		case (awaddr)
			`REG_CTRL, `REG_MTX, `REG_STX, `REG_DIV, `REG_STATUS, `REG_RESULT: wr_ok = 1'b1;
			default: wr_ok = 1'b0;
		endcase
	end

	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (araddr)
			`REG_CTRL:   rd_data = '0;                      // start is self clearing
			`REG_MTX:    rd_data = axil_data_t'(m_tx);
			`REG_STX:    rd_data = axil_data_t'(s_tx);
			`REG_DIV:    rd_data = axil_data_t'(div);
			`REG_STATUS: rd_data = axil_data_t'({done, busy});
			`REG_RESULT: rd_data = axil_data_t'({s_rx_q, m_rx_q});
			default:     rd_ok   = 1'b0;
		endcase
	end

	// bus response channels
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
			rdata  <= '0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_fire) begin
				rvalid <= 1'b1;
				rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
				rdata  <= rd_data;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// config registers and transfer tracking
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			m_tx   <= '0;
			s_tx   <= '0;
			div    <= spi_div_t'(`SPI_MIN_DIV);
			start  <= 1'b0;
			busy   <= 1'b0;
			done   <= 1'b0;
			m_seen <= 1'b0;
			s_seen <= 1'b0;
			m_rx_q <= '0;
			s_rx_q <= '0;
		end else begin
			start <= start_req;
			if (wr_fire) begin
				case (awaddr)
					`REG_MTX: m_tx <= spi_byte_t'(wdata);
					`REG_STX: s_tx <= spi_byte_t'(wdata);
					`REG_DIV: div  <= (wr_div < `SPI_MIN_DIV) ? spi_div_t'(`SPI_MIN_DIV) : wr_div;
					default: ;
				endcase
			end
			if (m_done) begin
				m_rx_q <= m_rx;
				m_seen <= 1'b1;
			end
			if (s_rx_valid) begin
				s_rx_q <= s_rx;
				s_seen <= 1'b1;
			end
			if (start_req) begin
				busy   <= 1'b1;
				done   <= 1'b0;
				m_seen <= 1'b0;
				s_seen <= 1'b0;
			end else if (busy && m_seen && s_seen) begin
				busy   <= 1'b0;            // both bytes in
				done   <= 1'b1;
				m_seen <= 1'b0;
				s_seen <= 1'b0;
			end
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		bvalid && !bready |=> bvalid);

endmodule

// ==== verilog/spi_link_top.sv ====
//************************************************
// spi_link_top
// register block with master and slave in loopback
//************************************************
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_link_top
	import axil_pkg::*;
	import spi_pkg::*;
#(
	parameter bit CPOL = `SPI_CPOL,
	parameter bit CPHA = `SPI_CPHA
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready
);

	logic      start, m_busy, m_done, s_rx_valid;
	spi_byte_t m_tx, m_rx, s_tx, s_rx;
	spi_div_t  div;
	logic      cs, sclk, mosi, miso;     // internal spi wires

	spi_ctrl_regs spi_ctrl_regs_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.start      (start),
		.m_tx       (m_tx),
		.div        (div),
		.m_busy     (m_busy),
		.m_done     (m_done),
		.m_rx       (m_rx),
		.s_tx       (s_tx),
		.s_rx       (s_rx),
		.s_rx_valid (s_rx_valid)
	);

	spi_master #(.CPOL(CPOL), .CPHA(CPHA)) spi_master_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.start     (start),
		.tx_byte   (m_tx),
		.div       (div),
		.busy      (m_busy),
		.done      (m_done),
		.rx_byte   (m_rx),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso)
	);

	spi_slave #(.CPOL(CPOL), .CPHA(CPHA)) spi_slave_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.tx_byte   (s_tx),
		.rx_byte   (s_rx),
		.rx_valid  (s_rx_valid)
	);

endmodule

// ==== verilog/spi_master.sv ====
//************************************************
// spi_master
// drives cs and sclk, swaps one byte with the slave
// half period of div+1 sys_clk cycles
//************************************************
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_master
	import spi_pkg::*;
#(
	parameter bit CPOL = `SPI_CPOL,     // idle sclk level
	parameter bit CPHA = `SPI_CPHA      // sample on trailing edge when set
) (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      start,            // one cycle request
	input  spi_byte_t tx_byte,
	input  spi_div_t  div,
	output logic      busy,
	output logic      done,             // one cycle, with cs rising
	output spi_byte_t rx_byte,
	output logic      cs,               // active low
	output logic      sclk,
	output logic      mosi,
	input  logic      miso
);

	master_state_t state;
	spi_div_t      cnt_clk;             // cycles within a half period
	logic [4:0]    edge_cnt;            // sclk edges issued so far
	spi_byte_t     tx_shift;
	spi_byte_t     rx_shift;
	logic          half_end;
	logic          shift_edge;
	logic          sample_edge;

	assign half_end = (cnt_clk + 1'b1 >= div);
	assign mosi     = tx_shift[`SPI_DATA_W-1];   // msb first
	assign rx_byte  = rx_shift;

	// even edges lead, odd edges trail
	// with CPHA=1 the first leading edge only presents the msb already on mosi
	assign shift_edge  = CPHA ? (!edge_cnt[0] && edge_cnt != 5'd0) : edge_cnt[0];
	assign sample_edge = CPHA ? edge_cnt[0] : !edge_cnt[0];

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state    <= M_IDLE;
			cnt_clk  <= '0;
			edge_cnt <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
			cs       <= 1'b1;
			sclk     <= CPOL;
		end else begin
			done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (start) begin
						state    <= M_HALF;
						busy     <= 1'b1;
						cs       <= 1'b0;     // cs low the cycle after start
						cnt_clk  <= '0;
						edge_cnt <= '0;
					end
				end
				M_HALF: begin
					if (half_end) begin
						state   <= M_EDGE;
						cnt_clk <= '0;
					end else begin
						cnt_clk <= cnt_clk + 1'b1;
					end
				end
				M_EDGE: begin
					sclk     <= ~sclk;
					edge_cnt <= edge_cnt + 5'd1;
					state    <= (edge_cnt == 5'd15) ? M_LAST : M_HALF;
				end
				M_LAST: begin
					if (half_end) begin
						state   <= M_DONE;
						cnt_clk <= '0;
					end else begin
						cnt_clk <= cnt_clk + 1'b1;
					end
				end
				M_DONE: begin
					state <= M_IDLE;
					busy  <= 1'b0;
					done  <= 1'b1;
					cs    <= 1'b1;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// shift registers, loaded at start
	always_ff @(posedge sys_clk) begin
		if (state == M_IDLE && start)
			tx_shift <= tx_byte;
		else if (state == M_EDGE && shift_edge)
			tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
		if (state == M_EDGE && sample_edge)
			rx_shift <= {rx_shift[`SPI_DATA_W-2:0], miso};
	end

	// busy and state must agree across a whole frame
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		state == M_IDLE |-> !busy);

endmodule

// ==== verilog/spi_params.svh ====
//************************************************
// spi link parameters
// widths, default SPI mode and register offsets
//************************************************
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// spi side
`define SPI_DATA_W      8           // bits per frame
`define SPI_DIV_W       16          // half period counter width
`define SPI_MIN_DIV     3           // keeps sclk levels visible through the slave sync
`define SPI_CPOL        1'b1        // idle clock level
`define SPI_CPHA        1'b1        // sample on trailing edge

// host bus
`define AXIL_ADDR_W     8
`define AXIL_DATA_W     32

// register map
`define REG_CTRL        8'h00       // bit0 start
`define REG_MTX         8'h04       // master tx byte
`define REG_STX         8'h08       // slave tx byte
`define REG_DIV         8'h0C       // half period divider
`define REG_STATUS      8'h10       // bit0 busy, bit1 done
`define REG_RESULT      8'h14       // [7:0] master rx, [15:8] slave rx

`endif

// ==== verilog/spi_pkg.sv ====
//************************************************
// spi_pkg
// byte and divider types, master and slave states
//************************************************
`include "spi_params.svh"

package spi_pkg;

	typedef logic [`SPI_DATA_W-1:0] spi_byte_t;     // shifted byte
	typedef logic [`SPI_DIV_W-1:0]  spi_div_t;      // half period count

	// master sequencing
	typedef enum logic [2:0] {
		M_IDLE,                     // cs high, waiting for start
		M_HALF,                     // counting out a half period
		M_EDGE,                     // one cycle where sclk toggles
		M_LAST,                     // final half period after edge 16
		M_DONE                      // release cs
	} master_state_t;

	// slave sequencing
	typedef enum logic [1:0] {
		S_IDLE,                     // waiting for cs to fall
		S_SHIFT,                    // frame in progress
		S_REPORT                    // hand the byte over
	} slave_state_t;

endpackage

// ==== verilog/spi_slave.sv ====
//************************************************
// spi_slave
// syncs cs and sclk into sys_clk, swaps one byte
//************************************************
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_slave
	import spi_pkg::*;
#(
	parameter bit CPOL = `SPI_CPOL,
	parameter bit CPHA = `SPI_CPHA
) (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      cs,
	input  logic      sclk,
	input  logic      mosi,
	output logic      miso,
	input  spi_byte_t tx_byte,
	output spi_byte_t rx_byte,
	output logic      rx_valid
);

	slave_state_t state;
	logic         cs_meta, cs_sync, cs_prev;
	logic         sclk_meta, sclk_sync, sclk_prev;
	logic         cs_fall, cs_rise;
	logic         lead_edge, trail_edge;
	logic         do_shift, do_sample;
	logic [3:0]   bit_cnt;              // bits sampled this frame
	spi_byte_t    tx_shift;
	spi_byte_t    rx_shift;

	// two flop sync plus one stage for edge detect
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_meta   <= 1'b1;
			cs_sync   <= 1'b1;
			cs_prev   <= 1'b1;
			sclk_meta <= CPOL;
			sclk_sync <= CPOL;
			sclk_prev <= CPOL;
		end else begin
			cs_meta   <= cs;
			cs_sync   <= cs_meta;
			cs_prev   <= cs_sync;
			sclk_meta <= sclk;
			sclk_sync <= sclk_meta;
			sclk_prev <= sclk_sync;
		end
	end

	assign cs_fall    = cs_prev & ~cs_sync;
	assign cs_rise    = ~cs_prev & cs_sync;
	assign lead_edge  = (sclk_prev == CPOL) && (sclk_sync != CPOL);   // away from idle
	assign trail_edge = (sclk_prev != CPOL) && (sclk_sync == CPOL);   // back to idle

	// CPHA=1 skips the first leading edge, msb is already out
	assign do_shift  = CPHA ? (lead_edge && bit_cnt != 4'd0) : trail_edge;
	assign do_sample = CPHA ? trail_edge : lead_edge;

	assign miso     = tx_shift[`SPI_DATA_W-1];
	assign rx_byte  = rx_shift;
	assign rx_valid = (state == S_REPORT);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state   <= S_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cs_fall) begin
						state   <= S_SHIFT;
						bit_cnt <= '0;
					end
				end
				S_SHIFT: begin
					if (cs_rise)
						state <= S_REPORT;
					else if (do_sample)
						bit_cnt <= bit_cnt + 4'd1;
				end
				S_REPORT: state <= S_IDLE;   // rx_valid for this cycle only
				default:  state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && cs_fall)
			tx_shift <= tx_byte;
		else if (state == S_SHIFT && do_shift)
			tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
		if (state == S_SHIFT && do_sample)
			rx_shift <= {rx_shift[`SPI_DATA_W-2:0], mosi};
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid);

endmodule
